// File: sources.f
design/mips_pkg.sv
design/pipe_reg.sv
design/fetch_pc.sv
design/decode_unit.sv
design/grf.sv
design/hazard_unit.sv
design/execute_unit.sv
design/mem_access.sv
design/mips.sv
dv/clk_gen.sv
dv/mips_checker.sv
dv/tb_mips.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - design/mips_pkg.sv
  - design/pipe_reg.sv
  - design/fetch_pc.sv
  - design/decode_unit.sv
  - design/grf.sv
  - design/hazard_unit.sv
  - design/execute_unit.sv
  - design/mem_access.sv
  - design/mips.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/mips_checker.sv
      - dv/tb_mips.sv

// File: dv/tb_mips.sv
`timescale 1ns/1ps

module tb_mips import mips_pkg::*; ();

	typedef enum logic [2:0] {ev_none, ev_wb, ev_load, ev_plus, ev_store} ev_t;

	// Slot is the word offset from reset_pc and rows follow retirement order
	typedef struct packed {
		logic [5:0] slot;
		word_t instr;
		ev_t ev;
		reg_idx_t rd;
		word_t addr;
		logic [3:0] be;
		word_t data;
	} row_t;

	localparam int rows = 45;
	localparam int limit = rows * 4 + 50;

	logic clk;
	logic arst_n;
	word_t i_inst_addr;
	word_t i_inst_rdata;
	word_t m_data_addr;
	word_t m_data_wdata;
	word_t m_data_rdata;
	word_t m_inst_addr;
	logic [3:0] m_data_byteen;
	logic w_grf_we;
	reg_idx_t w_grf_addr;
	word_t w_grf_wdata;
	word_t w_inst_addr;
	int mismatches;
	int other_errors;
	logic idle;

	row_t prog [rows];
	word_t imem [64];
	word_t dmem [16];
	word_t shadow [16];

	clk_gen clocks (.clk(clk), .arst_n(arst_n));

	mips dut (
		.clk(clk), .arst_n(arst_n), .i_inst_rdata(i_inst_rdata), .m_data_rdata(m_data_rdata),
		.i_inst_addr(i_inst_addr), .m_data_addr(m_data_addr), .m_data_wdata(m_data_wdata),
		.m_data_byteen(m_data_byteen), .m_inst_addr(m_inst_addr), .w_grf_we(w_grf_we),
		.w_grf_addr(w_grf_addr), .w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr)
	);

	mips_checker chk (
		.clk(clk), .arst_n(arst_n), .w_grf_we(w_grf_we), .w_grf_addr(w_grf_addr),
		.w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr), .m_data_byteen(m_data_byteen),
		.m_data_addr(m_data_addr), .m_data_wdata(m_data_wdata), .m_inst_addr(m_inst_addr),
		.mismatches(mismatches), .other_errors(other_errors), .idle(idle)
	);

	// Outside the program window the fetch sees nops
	assign i_inst_rdata = (i_inst_addr[31:8] == reset_pc[31:8]) ? imem[i_inst_addr[7:2]] : '0;
	assign m_data_rdata = dmem[m_data_addr[5:2]];

	always @(posedge clk) begin
		for (int k = 0; k < 4; k++) begin
			if (m_data_byteen[k]) begin
				dmem[m_data_addr[5:2]][8*k +: 8] <= m_data_wdata[8*k +: 8];
			end
		end
	end

	function automatic word_t r_type(input logic [5:0] funct, input int rs, input int rt,
			input int rd);
		return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input int rs, input int rt,
			input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t j_type(input logic [5:0] op, input int slot);
		word_t target;
		target = (reset_pc >> 2) + slot;
		return {op, target[25:0]};
	endfunction

	// Byte loads take the addressed lane and extend it
	function automatic word_t extend(input logic [5:0] opcode, input word_t word,
			input logic [1:0] lane);
		logic [7:0] b;
		b = word[8*lane +: 8];
		if (opcode == op_lb) begin
			return {{24{b[7]}}, b};
		end
		if (opcode == op_lbu) begin
			return {24'd0, b};
		end
		return word;
	endfunction

	initial begin
		word_t seed;
		word_t last;
		word_t pc;
		int cycles;
		int timeouts;
		seed = $urandom(32'h5875_5e47);
		prog = '{
			'{0, i_type(op_ori, 0, 1, 16'h1234), ev_wb, 1, 0, 0, 32'h0000_1234},
			'{1, i_type(op_lui, 0, 2, 16'habcd), ev_wb, 2, 0, 0, 32'habcd_0000},
			'{2, r_type(funct_addu, 1, 2, 3), ev_wb, 3, 0, 0, 32'habcd_1234},
			'{3, r_type(funct_subu, 3, 1, 4), ev_wb, 4, 0, 0, 32'habcd_0000},
			'{4, r_type(funct_and, 4, 3, 5), ev_wb, 5, 0, 0, 32'habcd_0000},
			'{5, r_type(funct_or, 5, 1, 6), ev_wb, 6, 0, 0, 32'habcd_1234},
			'{6, r_type(funct_slt, 6, 1, 7), ev_wb, 7, 0, 0, 32'h0000_0001},
			'{7, i_type(op_addiu, 7, 8, 16'hfffd), ev_wb, 8, 0, 0, 32'hffff_fffe},
			'{8, r_type(funct_slt, 1, 8, 9), ev_wb, 9, 0, 0, 32'h0000_0000},
			'{9, i_type(op_addiu, 1, 0, 16'h0005), ev_none, 0, 0, 0, 0},
			'{10, r_type(funct_or, 0, 1, 10), ev_wb, 10, 0, 0, 32'h0000_1234},
			'{11, i_type(op_lw, 0, 11, 16'h0008), ev_load, 11, 32'h08, 0, 0},
			'{12, i_type(op_addiu, 11, 12, 16'h0010), ev_plus, 12, 0, 0, 32'h10},
			'{13, i_type(op_lb, 0, 13, 16'h0005), ev_load, 13, 32'h05, 0, 0},
			'{14, i_type(op_addiu, 13, 14, 16'h0001), ev_plus, 14, 0, 0, 32'h01},
			'{15, i_type(op_lbu, 0, 15, 16'h0007), ev_load, 15, 32'h07, 0, 0},
			'{16, i_type(op_addiu, 15, 16, 16'h0000), ev_plus, 16, 0, 0, 32'h00},
			'{17, i_type(op_sb, 0, 1, 16'h0011), ev_store, 0, 32'h11, 4'b0010, 32'h0000_3400},
			'{18, i_type(op_addiu, 0, 18, 16'h0077), ev_wb, 18, 0, 0, 32'h0000_0077},
			'{19, i_type(op_sb, 0, 18, 16'h0013), ev_store, 0, 32'h13, 4'b1000, 32'h7700_0000},
			'{20, i_type(op_sw, 0, 6, 16'h0014), ev_store, 0, 32'h14, 4'b1111, 32'habcd_1234},
			'{21, i_type(op_lw, 0, 19, 16'h0010), ev_load, 19, 32'h10, 0, 0},
			'{22, i_type(op_lw, 0, 20, 16'h0014), ev_load, 20, 32'h14, 0, 0},
			'{23, i_type(op_sw, 0, 20, 16'h0018), ev_store, 0, 32'h18, 4'b1111, 32'habcd_1234},
			'{24, i_type(op_addiu, 0, 21, 16'h0005), ev_wb, 21, 0, 0, 32'h0000_0005},
			'{25, i_type(op_beq, 21, 0, 16'h0004), ev_none, 0, 0, 0, 0},
			'{26, i_type(op_addiu, 0, 22, 16'h0001), ev_wb, 22, 0, 0, 32'h0000_0001},
			'{27, i_type(op_bne, 22, 0, 16'h0003), ev_none, 0, 0, 0, 0},
			'{28, i_type(op_addiu, 0, 23, 16'h1234), ev_wb, 23, 0, 0, 32'h0000_1234},
			'{29, i_type(op_addiu, 0, 24, 16'h0099), ev_none, 0, 0, 0, 0},
			'{30, i_type(op_addiu, 0, 24, 16'h0098), ev_none, 0, 0, 0, 0},
			'{31, i_type(op_beq, 23, 1, 16'h0002), ev_none, 0, 0, 0, 0},
			'{32, i_type(op_addiu, 0, 25, 16'h0003), ev_wb, 25, 0, 0, 32'h0000_0003},
			'{33, i_type(op_addiu, 0, 25, 16'h0055), ev_none, 0, 0, 0, 0},
			'{34, j_type(op_jal, 40), ev_wb, 31, 0, 0, 32'h0000_3090},
			'{35, i_type(op_addiu, 0, 26, 16'h0004), ev_wb, 26, 0, 0, 32'h0000_0004},
			'{40, i_type(op_addiu, 31, 27, 16'h0004), ev_wb, 27, 0, 0, 32'h0000_3094},
			'{41, r_type(funct_jr, 31, 0, 0), ev_none, 0, 0, 0, 0},
			'{42, i_type(op_addiu, 0, 28, 16'h0006), ev_wb, 28, 0, 0, 32'h0000_0006},
			'{36, i_type(op_addiu, 0, 29, 16'h0007), ev_wb, 29, 0, 0, 32'h0000_0007},
			'{37, j_type(op_j, 43), ev_none, 0, 0, 0, 0},
			'{38, i_type(op_addiu, 0, 30, 16'h0008), ev_wb, 30, 0, 0, 32'h0000_0008},
			'{39, i_type(op_addiu, 0, 30, 16'h0066), ev_none, 0, 0, 0, 0},
			'{43, r_type(funct_addu, 30, 30, 0), ev_none, 0, 0, 0, 0},
			'{44, r_type(funct_or, 0, 30, 3), ev_wb, 3, 0, 0, 32'h0000_0008}
		};
		for (int i = 0; i < 64; i++) begin
			imem[i] = '0;
		end
		// Top bits of lanes 1 and 3 set so lb and lbu give different results
		for (int i = 0; i < 16; i++) begin
			dmem[i] = $urandom() | 32'h8000_8000;
			shadow[i] = dmem[i];
		end
		last = '0;
		timeouts = 0;
		for (int i = 0; i < rows; i++) begin
			imem[prog[i].slot] = prog[i].instr;
			pc = reset_pc + 4 * prog[i].slot;
			case (prog[i].ev)
				ev_wb: last = prog[i].data;
				ev_load: last = extend(prog[i].instr[31:26], shadow[prog[i].addr[5:2]],
					prog[i].addr[1:0]);
				ev_plus: last = last + prog[i].data;
				ev_store: begin
					for (int k = 0; k < 4; k++) begin
						if (prog[i].be[k]) begin
							shadow[prog[i].addr[5:2]][8*k +: 8] = prog[i].data[8*k +: 8];
						end
					end
					chk.store_due(pc, prog[i].addr, prog[i].be, prog[i].data);
				end
				default: ;
			endcase
			if (prog[i].ev inside {ev_wb, ev_load, ev_plus}) begin
				chk.wb_due(pc, prog[i].rd, last);
			end
		end

		wait (arst_n);
		cycles = 0;
		while (!idle && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!idle) begin
			timeouts++;
			$display("timeout: expected events still pending after %0d cycles", limit);
		end
		// Extra cycles to catch stray retirements after the last row
		repeat (10) @(negedge clk);
		$display("errors: %0d mismatch, %0d other", mismatches, other_errors + timeouts);
		if (mismatches == 0 && other_errors + timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: dv/mips_checker.sv
`timescale 1ns/1ps

module mips_checker import mips_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic w_grf_we,
	input reg_idx_t w_grf_addr,
	input word_t w_grf_wdata,
	input word_t w_inst_addr,
	input logic [3:0] m_data_byteen,
	input word_t m_data_addr,
	input word_t m_data_wdata,
	input word_t m_inst_addr,
	output int mismatches,
	output int other_errors,
	output logic idle
);

	typedef struct packed {
		word_t pc;
		reg_idx_t rd;
		word_t data;
	} wb_ev_t;

	typedef struct packed {
		word_t pc;
		word_t addr;
		logic [3:0] be;
		word_t data;
	} st_ev_t;

	// Expected events in retirement order
	wb_ev_t wb_q [$];
	st_ev_t st_q [$];

	task automatic wb_due(input word_t pc, input reg_idx_t rd, input word_t data);
		wb_q.push_back('{pc: pc, rd: rd, data: data});
	endtask

	task automatic store_due(input word_t pc, input word_t addr, input logic [3:0] be,
			input word_t data);
		st_q.push_back('{pc: pc, addr: addr, be: be, data: data});
	endtask

	task automatic compare(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			mismatches++;
			$display("mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	// Outputs are sampled on the edge that ends the cycle
	always @(posedge clk or negedge arst_n) begin
		wb_ev_t w;
		st_ev_t s;
		if (!arst_n) begin
			mismatches = 0;
			other_errors = 0;
			idle = 1'b0;
		end else begin
			if (w_grf_we && w_grf_addr == '0) begin
				other_errors++;
				$display("register 0 write reported with the enable high at pc %h", w_inst_addr);
			end
			if (w_grf_we) begin
				if (wb_q.size() == 0) begin
					other_errors++;
					$display("unexpected register write to r%0d at pc %h", w_grf_addr, w_inst_addr);
				end else begin
					w = wb_q.pop_front();
					compare("w_inst_addr", w_inst_addr, w.pc);
					compare("w_grf_addr", {27'd0, w_grf_addr}, {27'd0, w.rd});
					compare("w_grf_wdata", w_grf_wdata, w.data);
				end
			end
			if (m_data_byteen != 4'b0000) begin
				if (st_q.size() == 0) begin
					other_errors++;
					$display("unexpected data memory write to %h at pc %h", m_data_addr, m_inst_addr);
				end else begin
					s = st_q.pop_front();
					compare("m_inst_addr", m_inst_addr, s.pc);
					compare("m_data_addr", m_data_addr, s.addr);
					compare("m_data_byteen", {28'd0, m_data_byteen}, {28'd0, s.be});
					compare("m_data_wdata", m_data_wdata, s.data);
				end
			end
			idle = (wb_q.size() == 0) && (st_q.size() == 0);
		end
	end

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic arst_n
);

	localparam int half_period = 20;
	localparam int reset_cycles = 5;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// File: design/mips.sv
`timescale 1ns/1ps

module mips import mips_pkg::*; (
	input logic clk,
	input logic arst_n,
	input word_t i_inst_rdata,
	input word_t m_data_rdata,
	output word_t i_inst_addr,
	output word_t m_data_addr,
	output word_t m_data_wdata,
	output logic [3:0] m_data_byteen,
	output word_t m_inst_addr,
	output logic w_grf_we,
	output reg_idx_t w_grf_addr,
	output word_t w_grf_wdata,
	output word_t w_inst_addr
);

	fd_t f_fd, d_fd;
	de_t d_de, e_de;
	em_t e_em, m_em;
	mw_t m_mw, w_mw;
	reg_wr_t w_wr;
	word_t f_pc;
	ctrl_t d_ctrl;
	reg_idx_t d_rs, d_rt;
	word_t d_imm, d_branch_target, d_jump_target;
	logic d_branch_taken;
	word_t d_grf_a, d_grf_b, d_rs_val, d_rt_val;
	word_t e_rs_val, e_rt_val, e_alu, e_fwd;
	word_t m_store, m_load, m_fwd;
	word_t w_wdata;
	logic stall;
	fwd_sel_t fwd_d_rs, fwd_d_rt, fwd_e_rs, fwd_e_rt, fwd_m_rt;

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t own, input word_t ex_val,
			input word_t mem_val, input word_t wb_val);
		case (sel)
			fwd_ex: return ex_val;
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return own;
		endcase
	endfunction

	// Fetch
	fetch_pc fetch_pc (
		.clk(clk), .arst_n(arst_n), .stall(stall), .npc_sel(d_ctrl.npc_sel),
		.branch_taken(d_branch_taken), .branch_target(d_branch_target),
		.jump_target(d_jump_target), .jr_target(d_rs_val), .pc(f_pc)
	);
	assign i_inst_addr = f_pc;
	assign f_fd = '{instr: i_inst_rdata, pc: f_pc};

	pipe_reg #(.T(fd_t)) fd_reg (
		.clk(clk), .arst_n(arst_n), .stall(stall), .flush(1'b0), .d(f_fd), .q(d_fd)
	);

	// Decode
	decode_unit decode_unit (
		.fd(d_fd), .rs_val(d_rs_val), .rt_val(d_rt_val), .ctrl(d_ctrl), .rs(d_rs), .rt(d_rt),
		.imm_ext(d_imm), .branch_target(d_branch_target), .jump_target(d_jump_target),
		.branch_taken(d_branch_taken)
	);
	grf grf (
		.clk(clk), .arst_n(arst_n), .ra(d_rs), .rb(d_rt), .wr(w_wr),
		.rdata_a(d_grf_a), .rdata_b(d_grf_b)
	);
	hazard_unit hazard_unit (
		.dec_ctrl(d_ctrl), .dec_rs(d_rs), .dec_rt(d_rt), .ex(e_de), .mem(m_em), .wb(w_wr),
		.stall(stall), .fwd_d_rs(fwd_d_rs), .fwd_d_rt(fwd_d_rt), .fwd_e_rs(fwd_e_rs),
		.fwd_e_rt(fwd_e_rt), .fwd_m_rt(fwd_m_rt)
	);
	assign d_rs_val = fwd_mux(fwd_d_rs, d_grf_a, e_fwd, m_fwd, w_wr.data);
	assign d_rt_val = fwd_mux(fwd_d_rt, d_grf_b, e_fwd, m_fwd, w_wr.data);
	assign d_de = '{ctrl: d_ctrl, rs: d_rs, rt: d_rt, rs_val: d_rs_val, rt_val: d_rt_val,
		imm: d_imm, pc: d_fd.pc};

	// A stall leaves a bubble in execute
	pipe_reg #(.T(de_t)) de_reg (
		.clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(stall), .d(d_de), .q(e_de)
	);

	// Execute
	assign e_rs_val = fwd_mux(fwd_e_rs, e_de.rs_val, e_fwd, m_fwd, w_wr.data);
	assign e_rt_val = fwd_mux(fwd_e_rt, e_de.rt_val, e_fwd, m_fwd, w_wr.data);
	execute_unit execute_unit (.de(e_de), .rs_val(e_rs_val), .rt_val(e_rt_val), .result(e_alu));
	// Only a jal result is ready this early
	assign e_fwd = (e_de.ctrl.wsel == wsel_link) ? e_de.pc + 32'd8 : e_alu;
	assign e_em = '{ctrl: e_de.ctrl, rt: e_de.rt, alu: e_alu, store_val: e_rt_val,
		pc: e_de.pc};

	pipe_reg #(.T(em_t)) em_reg (
		.clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0), .d(e_em), .q(m_em)
	);

	// Memory
	assign m_store = fwd_mux(fwd_m_rt, m_em.store_val, e_fwd, m_fwd, w_wr.data);
	mem_access mem_access (
		.kind(m_em.ctrl.mem_kind), .addr(m_em.alu), .store_val(m_store), .rdata(m_data_rdata),
		.byteen(m_data_byteen), .wdata(m_data_wdata), .load_val(m_load)
	);
	assign m_data_addr = m_em.alu;
	assign m_inst_addr = m_em.pc;
	assign m_fwd = (m_em.ctrl.wsel == wsel_link) ? m_em.pc + 32'd8 : m_em.alu;
	assign m_mw = '{ctrl: m_em.ctrl, alu: m_em.alu, load: m_load, pc: m_em.pc};

	pipe_reg #(.T(mw_t)) mw_reg (
		.clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0), .d(m_mw), .q(w_mw)
	);

	// Writeback
	always_comb begin
		case (w_mw.ctrl.wsel)
			wsel_load: w_wdata = w_mw.load;
			wsel_link: w_wdata = w_mw.pc + 32'd8;
			default: w_wdata = w_mw.alu;
		endcase
	end
	assign w_wr = '{we: w_mw.ctrl.reg_write, addr: w_mw.ctrl.dest, data: w_wdata};

	assign w_grf_we = w_wr.we;
	assign w_grf_addr = w_wr.addr;
	assign w_grf_wdata = w_wr.data;
	assign w_inst_addr = w_mw.pc;

endmodule

// File: design/mem_access.sv
`timescale 1ns/1ps

module mem_access import mips_pkg::*; (
	input mem_kind_t kind,
	input word_t addr,
	input word_t store_val,
	input word_t rdata,
	output logic [3:0] byteen,
	output word_t wdata,
	output word_t load_val
);

	logic [1:0] lane;
	logic [7:0] byte_val;

	assign lane = addr[1:0];

	// Byte stores go out on the addressed lane only
	always_comb begin
		byteen = 4'b0000;
		wdata = store_val;
		case (kind)
			mem_sw: byteen = 4'b1111;
			mem_sb: begin
				byteen = 4'b0001 << lane;
				wdata = {24'd0, store_val[7:0]} << (8 * lane);
			end
			default: ;
		endcase
	end

	assign byte_val = rdata[8 * lane +: 8];

	always_comb begin
		case (kind)
			mem_lb: load_val = {{24{byte_val[7]}}, byte_val};
			mem_lbu: load_val = {24'd0, byte_val};
			default: load_val = rdata;
		endcase
	end

	// Program must keep lw and sw addresses word aligned
	a_word_aligned: assert final (!(kind == mem_lw || kind == mem_sw) || lane == 2'b00);

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import mips_pkg::*; (
	input de_t de,
	input word_t rs_val,
	input word_t rt_val,
	output word_t result
);

	word_t op_b;

	assign op_b = de.ctrl.alu_src_imm ? de.imm : rt_val;

	always_comb begin
		case (de.ctrl.alu_op)
			alu_sub: result = rs_val - op_b;
			alu_and: result = rs_val & op_b;
			alu_or: result = rs_val | op_b;
			alu_slt: result = {31'd0, $signed(rs_val) < $signed(op_b)};
			// Upper half from the immediate, lower half cleared
			alu_lui: result = {op_b[15:0], 16'h0000};
			default: result = rs_val + op_b;
		endcase
	end

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
	input ctrl_t dec_ctrl,
	input reg_idx_t dec_rs,
	input reg_idx_t dec_rt,
	input de_t ex,
	input em_t mem,
	input reg_wr_t wb,
	output logic stall,
	output fwd_sel_t fwd_d_rs,
	output fwd_sel_t fwd_d_rt,
	output fwd_sel_t fwd_e_rs,
	output fwd_sel_t fwd_e_rt,
	output fwd_sel_t fwd_m_rt
);

	logic [1:0] tnew_e;
	logic [1:0] tnew_m;
	logic stall_rs;
	logic stall_rt;

	function automatic logic hit(input logic we, input reg_idx_t dest, input reg_idx_t r);
		return we && dest == r && r != '0;
	endfunction

	// Newest producer wins even when not ready yet and a later stage then supplies it
	function automatic fwd_sel_t newest(input logic near_hit, input logic near_rdy,
			input fwd_sel_t near_src, input logic far_hit, input fwd_sel_t far_src);
		if (near_hit) begin
			return near_rdy ? near_src : fwd_reg;
		end
		return far_hit ? far_src : fwd_reg;
	endfunction

	assign tnew_e = ex.ctrl.t_new;
	// One cycle closer to ready than in execute
	assign tnew_m = (mem.ctrl.t_new == 2'd0) ? 2'd0 : mem.ctrl.t_new - 2'd1;

	// tuse_none is above any Tnew so unused operands never stall
	assign stall_rs =
		(hit(ex.ctrl.reg_write, ex.ctrl.dest, dec_rs) && tnew_e > dec_ctrl.use_rs) ||
		(hit(mem.ctrl.reg_write, mem.ctrl.dest, dec_rs) && tnew_m > dec_ctrl.use_rs);
	assign stall_rt =
		(hit(ex.ctrl.reg_write, ex.ctrl.dest, dec_rt) && tnew_e > dec_ctrl.use_rt) ||
		(hit(mem.ctrl.reg_write, mem.ctrl.dest, dec_rt) && tnew_m > dec_ctrl.use_rt);
	assign stall = stall_rs || stall_rt;

	// Writeback reaches decode through the register file bypass
	assign fwd_d_rs = newest(hit(ex.ctrl.reg_write, ex.ctrl.dest, dec_rs), tnew_e == 2'd0,
		fwd_ex, hit(mem.ctrl.reg_write, mem.ctrl.dest, dec_rs) && tnew_m == 2'd0, fwd_mem);
	assign fwd_d_rt = newest(hit(ex.ctrl.reg_write, ex.ctrl.dest, dec_rt), tnew_e == 2'd0,
		fwd_ex, hit(mem.ctrl.reg_write, mem.ctrl.dest, dec_rt) && tnew_m == 2'd0, fwd_mem);

	assign fwd_e_rs = newest(hit(mem.ctrl.reg_write, mem.ctrl.dest, ex.rs), tnew_m == 2'd0,
		fwd_mem, hit(wb.we, wb.addr, ex.rs), fwd_wb);
	assign fwd_e_rt = newest(hit(mem.ctrl.reg_write, mem.ctrl.dest, ex.rt), tnew_m == 2'd0,
		fwd_mem, hit(wb.we, wb.addr, ex.rt), fwd_wb);

	// Store data late from a load directly ahead
	assign fwd_m_rt = hit(wb.we, wb.addr, mem.rt) ? fwd_wb : fwd_reg;

	// An execute-stage user of a memory-stage result only gets there once it is ready
	a_e_rs_ready: assert final (!(ex.ctrl.use_rs == tuse_e &&
		hit(mem.ctrl.reg_write, mem.ctrl.dest, ex.rs)) || fwd_e_rs == fwd_mem);
	a_e_rt_ready: assert final (!(ex.ctrl.use_rt == tuse_e &&
		hit(mem.ctrl.reg_write, mem.ctrl.dest, ex.rt)) || fwd_e_rt == fwd_mem);

endmodule

// File: design/grf.sv
`timescale 1ns/1ps

module grf import mips_pkg::*; (
	input logic clk,
	input logic arst_n,
	input reg_idx_t ra,
	input reg_idx_t rb,
	input reg_wr_t wr,
	output word_t rdata_a,
	output word_t rdata_b
);

	// Register 0 has no storage
	word_t regs [1:reg_count-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.we && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rdata_a = (ra == '0) ? '0 : (wr.we && wr.addr == ra) ? wr.data : regs[ra];
	assign rdata_b = (rb == '0) ? '0 : (wr.we && wr.addr == rb) ? wr.data : regs[rb];

	// Decode clears reg_write for register 0 and nothing downstream may set it again
	a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
		wr.we |-> wr.addr != '0);

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import mips_pkg::*; (
	input fd_t fd,
	input word_t rs_val,
	input word_t rt_val,
	output ctrl_t ctrl,
	output reg_idx_t rs,
	output reg_idx_t rt,
	output word_t imm_ext,
	output word_t branch_target,
	output word_t jump_target,
	output logic branch_taken
);

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t rd;
	logic [15:0] imm16;
	word_t pc_next;
	alu_op_t r_op;
	logic r_valid;

	assign opcode = fd.instr[31:26];
	assign rs = fd.instr[25:21];
	assign rt = fd.instr[20:16];
	assign rd = fd.instr[15:11];
	assign funct = fd.instr[5:0];
	assign imm16 = fd.instr[15:0];
	assign pc_next = fd.pc + 32'd4;

	// ori is the only zero-extended immediate
	assign imm_ext = (opcode == op_ori) ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
	assign branch_target = pc_next + {imm_ext[29:0], 2'b00};
	assign jump_target = {pc_next[31:28], fd.instr[25:0], 2'b00};
	assign branch_taken = (ctrl.npc_sel == npc_branch) &&
		((rs_val == rt_val) != ctrl.branch_ne);

	// R-type ALU operations
	always_comb begin
		r_valid = 1'b1;
		case (funct)
			funct_addu: r_op = alu_add;
			funct_subu: r_op = alu_sub;
			funct_and: r_op = alu_and;
			funct_or: r_op = alu_or;
			funct_slt: r_op = alu_slt;
			default: begin
				r_op = alu_add;
				r_valid = 1'b0;
			end
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.use_rs = tuse_none;
		ctrl.use_rt = tuse_none;
		case (opcode)
			op_special: begin
				if (funct == funct_jr) begin
					ctrl.npc_sel = npc_jr;
					ctrl.use_rs = tuse_d;
				end else if (r_valid) begin
					ctrl.alu_op = r_op;
					ctrl.reg_write = 1'b1;
					ctrl.dest = rd;
					ctrl.use_rs = tuse_e;
					ctrl.use_rt = tuse_e;
					ctrl.t_new = 2'd1;
				end
			end
			op_addiu, op_ori, op_lui: begin
				ctrl.alu_op = (opcode == op_addiu) ? alu_add :
					(opcode == op_ori) ? alu_or : alu_lui;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = rt;
				ctrl.use_rs = (opcode == op_lui) ? tuse_none : tuse_e;
				ctrl.t_new = 2'd1;
			end
			op_lw, op_lb, op_lbu: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.wsel = wsel_load;
				ctrl.reg_write = 1'b1;
				ctrl.dest = rt;
				ctrl.mem_kind = (opcode == op_lw) ? mem_lw :
					(opcode == op_lb) ? mem_lb : mem_lbu;
				ctrl.use_rs = tuse_e;
				// Load data exists only after the memory stage
				ctrl.t_new = 2'd2;
			end
			op_sw, op_sb: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_kind = (opcode == op_sw) ? mem_sw : mem_sb;
				ctrl.use_rs = tuse_e;
				ctrl.use_rt = tuse_m;
			end
			op_beq, op_bne: begin
				ctrl.npc_sel = npc_branch;
				ctrl.branch_ne = (opcode == op_bne);
				ctrl.use_rs = tuse_d;
				ctrl.use_rt = tuse_d;
			end
			op_j: ctrl.npc_sel = npc_jump;
			op_jal: begin
				ctrl.npc_sel = npc_jump;
				ctrl.wsel = wsel_link;
				ctrl.reg_write = 1'b1;
				ctrl.dest = 5'd31;
			end
			default: ;
		endcase
		// Writes to register 0 are dropped here
		if (ctrl.dest == '0) begin
			ctrl.reg_write = 1'b0;
		end
	end

endmodule

// File: design/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc import mips_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input npc_sel_t npc_sel,
	input logic branch_taken,
	input word_t branch_target,
	input word_t jump_target,
	input word_t jr_target,
	output word_t pc
);

	word_t pc_plus4;
	word_t next_pc;

	assign pc_plus4 = pc + 32'd4;

	// Decode holds the control transfer while fetch already points at its delay slot
	always_comb begin
		case (npc_sel)
			npc_branch: next_pc = branch_taken ? branch_target : pc_plus4;
			npc_jump: next_pc = jump_target;
			npc_jr: next_pc = jr_target;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
		end else if (!stall) begin
			pc <= next_pc;
		end
	end

endmodule

// File: design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type T = logic
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic flush,
	input T d,
	output T q
);

	// All-zero payload is a bubble: no register write, no memory access
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= T'('0);
		end else if (flush) begin
			q <= T'('0);
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_3000;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// Primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lb = 6'h20;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_lbu = 6'h24;
	localparam logic [5:0] op_sb = 6'h28;
	localparam logic [5:0] op_sw = 6'h2b;

	// Function codes under op_special
	localparam logic [5:0] funct_jr = 6'h08;
	localparam logic [5:0] funct_addu = 6'h21;
	localparam logic [5:0] funct_subu = 6'h23;
	localparam logic [5:0] funct_and = 6'h24;
	localparam logic [5:0] funct_or = 6'h25;
	localparam logic [5:0] funct_slt = 6'h2a;

	// Tuse in stages after decode
	localparam logic [1:0] tuse_d = 2'd0;
	localparam logic [1:0] tuse_e = 2'd1;
	localparam logic [1:0] tuse_m = 2'd2;
	localparam logic [1:0] tuse_none = 2'd3;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_lui} alu_op_t;
	typedef enum logic [1:0] {wsel_alu, wsel_load, wsel_link} wsel_t;
	typedef enum logic [1:0] {npc_seq, npc_branch, npc_jump, npc_jr} npc_sel_t;
	// fwd_ex is only ever chosen for decode operands
	typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb, fwd_ex} fwd_sel_t;
	typedef enum logic [2:0] {mem_none, mem_lw, mem_lb, mem_lbu, mem_sw, mem_sb} mem_kind_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic alu_src_imm;
		wsel_t wsel;
		logic reg_write;
		reg_idx_t dest;
		mem_kind_t mem_kind;
		npc_sel_t npc_sel;
		logic branch_ne;
		logic [1:0] use_rs;
		logic [1:0] use_rt;
		logic [1:0] t_new;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc;
	} fd_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t rs_val;
		word_t rt_val;
		word_t imm;
		word_t pc;
	} de_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_idx_t rt;
		word_t alu;
		word_t store_val;
		word_t pc;
	} em_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu;
		word_t load;
		word_t pc;
	} mw_t;

	typedef struct packed {
		logic we;
		reg_idx_t addr;
		word_t data;
	} reg_wr_t;

endpackage
